// File: logic/taylor_pkg.sv
/*
 Shared number format, enums and MAC slice control for the Taylor series trig unit.
 Imported by every RTL block that needs these definitions.
*/
package taylor_pkg;

    // ----------------------------------------------------------------------
    // Number format
    // ----------------------------------------------------------------------

    // Q2.16 fraction bits
    localparam int FRAC_BITS = 16;
    // Operand width of the slice
    localparam int FIX_W     = 18;
    // Full multiplier output width
    localparam int PROD_W    = 2 * FIX_W;
    // Accumulator width, as on a DSP48
    localparam int ACC_W     = 48;

    // Signed Q2.16 value
    typedef logic signed [FIX_W-1:0]  fix_t;
    // Raw product, Q4.32
    typedef logic signed [PROD_W-1:0] prod_t;
    // Accumulator register
    typedef logic signed [ACC_W-1:0]  acc_t;

    // 1.0 in Q2.16
    localparam fix_t ONE_FIX = 18'h10000;

    // ----------------------------------------------------------------------
    // Function select
    // ----------------------------------------------------------------------

    // Encoding is the start phase in the derivative cycle
    typedef enum logic [1:0] {
        FN_SIN     = 2'd0,
        FN_COS     = 2'd1,
        FN_NEG_SIN = 2'd2,
        FN_NEG_COS = 2'd3
    } func_t;

    // ----------------------------------------------------------------------
    // MAC slice control
    // ----------------------------------------------------------------------

    // Post-adder mode, applied in stage 2
    typedef enum logic [1:0] {
        MAC_IDLE = 2'd0,    // p cleared
        MAC_MUL  = 2'd1,    // p takes product only
        MAC_HOLD = 2'd2,    // p unchanged
        MAC_ACC  = 2'd3     // p plus product
    } mac_op_t;

    // Sequencer to slice, 38 bits
    typedef struct packed {
        mac_op_t op;
        fix_t    a;
        fix_t    b;
    } mac_ctl_t;

endpackage

// File: logic/taylor_coef_rom.sv
/*
 Coefficient tables for the Taylor sequencer. Gives 1/n in Q2.16 and the
 derivative sign of the selected function at term idx. Purely combinational.
*/
module taylor_coef_rom
    import taylor_pkg::*;
#(
    parameter int N_TERMS = 11
) (
    input  logic [3:0] idx,
    input  func_t      func,
    output fix_t       frac_coef,
    output fix_t       deriv_coef,
    output logic       last_idx
);

    // Position in the 0, +1, 0, -1 cycle
    logic [1:0] phase;

    // ----------------------------------------------------------------------
    // Reciprocals 1/n, rounded
    // ----------------------------------------------------------------------
    always_comb begin
        case (idx)
            4'h0:    frac_coef = ONE_FIX;     // Seeds q_0 = 1.0
            4'h1:    frac_coef = 18'h10000;
            4'h2:    frac_coef = 18'h08000;
            4'h3:    frac_coef = 18'h05555;
            4'h4:    frac_coef = 18'h04000;
            4'h5:    frac_coef = 18'h03333;
            4'h6:    frac_coef = 18'h02aab;
            4'h7:    frac_coef = 18'h02492;
            4'h8:    frac_coef = 18'h02000;
            4'h9:    frac_coef = 18'h01c72;
            4'ha:    frac_coef = 18'h0199a;
            // Spare entries for longer series
            4'hb:    frac_coef = 18'h01746;
            4'hc:    frac_coef = 18'h01555;
            4'hd:    frac_coef = 18'h013b1;
            4'he:    frac_coef = 18'h01249;
            default: frac_coef = 18'h01111;
        endcase
    end

    // ----------------------------------------------------------------------
    // Derivative at zero, sin-based cycle
    // ----------------------------------------------------------------------
    assign phase = func + idx[1:0];

    always_comb begin
        case (phase)
            2'd1:    deriv_coef = ONE_FIX;
            2'd3:    deriv_coef = -ONE_FIX;
            // Even phases vanish at zero
            default: deriv_coef = '0;
        endcase
    end

    // Final term of the series
    assign last_idx = (idx == 4'(N_TERMS - 1));

endmodule

// File: logic/dsp_mac.sv
/*
 Multiply-accumulate slice in the style of a DSP48. Stage 1 registers a*b,
 stage 2 runs the post-adder on p under the registered opcode.
*/
module dsp_mac
    import taylor_pkg::*;
(
    input  logic     reset,
    input  logic     clk,
    input  mac_ctl_t mac_ctl,
    output prod_t    m,
    output acc_t     p
);

    // Opcode travelling with the product
    mac_op_t op_q;
    // Product widened for the post-adder
    acc_t    m_ext;

    // ----------------------------------------------------------------------
    // Stage 1, multiplier register
    // ----------------------------------------------------------------------
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            m    <= '0;
            op_q <= MAC_IDLE;
        end else begin
            // Both operands signed, full 36-bit product
            m    <= prod_t'(mac_ctl.a) * prod_t'(mac_ctl.b);
            op_q <= mac_ctl.op;
        end
    end

    // Sign extension into the 48-bit adder
    assign m_ext = acc_t'(m);

    // ----------------------------------------------------------------------
    // Stage 2, post-adder and accumulator
    // ----------------------------------------------------------------------
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            p <= '0;
        end else begin
            case (op_q)
                MAC_IDLE: p <= '0;
                MAC_MUL:  p <= m_ext;
                MAC_HOLD: p <= p;
                MAC_ACC:  p <= p + m_ext;
                default:  p <= p;
            endcase
        end
    end

endmodule

// File: logic/taylor_calc.sv
/*
 Taylor series sequencer with req/ack front end. Forms x/n, chains them into
 x^n/n! and accumulates the signed terms, all through one shared MAC slice.
*/
module taylor_calc
    import taylor_pkg::*;
#(
    parameter int N_TERMS = 11
) (
    input  logic       reset,
    input  logic       clk,
    // Client side
    input  logic       req,
    input  func_t      func,
    input  fix_t       angle,
    output logic       ack,
    output fix_t       result,
    // MAC slice
    output mac_ctl_t   mac_ctl,
    input  prod_t      m,
    input  acc_t       p,
    // Coefficient tables
    output logic [3:0] idx,
    output func_t      func_q,
    input  fix_t       frac_coef,
    input  fix_t       deriv_coef,
    input  logic       last_idx
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_X_MUL_COEF,
        ST_POW_MUL,
        ST_POW_ACC,
        ST_WAIT,
        ST_ACK
    } state_t;

    state_t     state;
    state_t     state_nxt;
    // Second cycle of the drain wait
    logic       wait_cnt;

    // Latched angle
    fix_t       x_q;
    // Product rescaled to Q2.16
    fix_t       m_fix;

    // Write-back, one stage behind m
    logic       q_we_d;
    logic       t_we_d;
    logic [3:0] wr_idx_d;

    // Factor store q_n and power store t_n
    fix_t       q_mem [N_TERMS];
    fix_t       t_mem [N_TERMS];

    // ----------------------------------------------------------------------
    // State machine
    // ----------------------------------------------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (req) state_nxt = ST_X_MUL_COEF;
            end
            ST_X_MUL_COEF: begin
                if (last_idx) state_nxt = ST_POW_MUL;
            end
            ST_POW_MUL: begin
                state_nxt = ST_POW_ACC;
            end
            ST_POW_ACC: begin
                state_nxt = last_idx ? ST_WAIT : ST_POW_MUL;
            end
            ST_WAIT: begin
                // Last MAC_ACC has reached p
                if (wait_cnt) state_nxt = ST_ACK;
            end
            ST_ACK: begin
                if (!req) state_nxt = ST_IDLE;
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            state    <= ST_IDLE;
            idx      <= '0;
            wait_cnt <= 1'b0;
            ack      <= 1'b0;
            result   <= '0;
            q_we_d   <= 1'b0;
            t_we_d   <= 1'b0;
            wr_idx_d <= '0;
        end else begin
            state    <= state_nxt;
            wait_cnt <= (state == ST_WAIT) && !wait_cnt;

            // Term index, held across the multiply half of each pair
            case (state)
                ST_X_MUL_COEF, ST_POW_ACC: idx <= last_idx ? 4'd0 : idx + 4'd1;
                ST_POW_MUL:                idx <= idx;
                default:                   idx <= '0;
            endcase

            // Product lands in m one cycle later
            q_we_d   <= (state == ST_X_MUL_COEF);
            t_we_d   <= (state == ST_POW_MUL);
            wr_idx_d <= idx;

            // Capture once, then frozen while ack is high
            if (state == ST_ACK && !ack) begin
                result <= p[FRAC_BITS +: FIX_W];
            end
            // Drops on the edge that sees req low
            ack <= (state == ST_ACK) && req;
        end
    end

    // ----------------------------------------------------------------------
    // Request capture and product stores
    // ----------------------------------------------------------------------
    always_ff @(posedge reset) begin
        if (state == ST_IDLE && req) begin
            x_q    <= angle;
            func_q <= func;
        end
    end

    assign m_fix = m[FRAC_BITS +: FIX_W];

    always_ff @(posedge reset) begin
        if (q_we_d) begin
            q_mem[wr_idx_d] <= m_fix;
        end
        if (t_we_d) begin
            t_mem[wr_idx_d] <= m_fix;
        end
    end

    // ----------------------------------------------------------------------
    // Slice operand steering
    // ----------------------------------------------------------------------
    always_comb begin
        mac_ctl.op = MAC_IDLE;
        mac_ctl.a  = '0;
        mac_ctl.b  = '0;
        case (state)
            ST_X_MUL_COEF: begin
                // q_n = x/n, p cleared meanwhile
                // Index 0 gives q_0 = 1.0
                mac_ctl.a = (idx == 4'd0) ? ONE_FIX : x_q;
                mac_ctl.b = frac_coef;
            end
            ST_POW_MUL: begin
                // t_n = t_(n-1) * q_n, accumulator untouched
                mac_ctl.op = MAC_HOLD;
                mac_ctl.a  = (idx == 4'd0) ? ONE_FIX : t_mem[idx - 4'd1];
                mac_ctl.b  = q_mem[idx];
            end
            ST_POW_ACC: begin
                // t_n straight from m, weighted by the derivative
                mac_ctl.op = MAC_ACC;
                mac_ctl.a  = m_fix;
                mac_ctl.b  = deriv_coef;
            end
            ST_WAIT, ST_ACK: begin
                mac_ctl.op = MAC_HOLD;
            end
            default: begin
                mac_ctl.op = MAC_IDLE;
            end
        endcase
    end

endmodule

// File: logic/trig_unit.sv
/*
 Top level of the fixed-point trig unit. Joins the sequencer, coefficient
 tables and MAC slice. reset is the clock, clk the asynchronous reset.
*/
module trig_unit
    import taylor_pkg::*;
#(
    parameter int N_TERMS = 11
) (
    input  logic  reset,
    input  logic  clk,
    input  logic  req,
    input  func_t func,
    input  fix_t  angle,
    output logic  ack,
    output fix_t  result
);

    // Slice connections
    mac_ctl_t   mac_ctl;
    prod_t      m;
    acc_t       p;

    // Table lookups
    logic [3:0] idx;
    func_t      func_q;
    fix_t       frac_coef;
    fix_t       deriv_coef;
    logic       last_idx;

    // ----------------------------------------------------------------------
    // Sequencer
    // ----------------------------------------------------------------------
    taylor_calc #(
        .N_TERMS(N_TERMS)
    ) taylor_calc_i (
        .reset     (reset),
        .clk       (clk),
        .req       (req),
        .func      (func),
        .angle     (angle),
        .ack       (ack),
        .result    (result),
        .mac_ctl   (mac_ctl),
        .m         (m),
        .p         (p),
        .idx       (idx),
        .func_q    (func_q),
        .frac_coef (frac_coef),
        .deriv_coef(deriv_coef),
        .last_idx  (last_idx)
    );

    // Coefficients
    taylor_coef_rom #(
        .N_TERMS(N_TERMS)
    ) taylor_coef_rom_i (
        .idx       (idx),
        .func      (func_q),
        .frac_coef (frac_coef),
        .deriv_coef(deriv_coef),
        .last_idx  (last_idx)
    );

    // Shared MAC
    dsp_mac dsp_mac_i (
        .reset  (reset),
        .clk    (clk),
        .mac_ctl(mac_ctl),
        .m      (m),
        .p      (p)
    );

endmodule

// File: tests/tb_clock.sv
/*
 Clock and reset source for the trig unit testbench. reset toggles as a
 20 ns clock, clk holds the DUT in reset for the first 2 cycles.
*/
module tb_clock #(
    parameter int HALF_NS = 10
) (
    output logic reset,
    output logic clk
);

    timeunit 1ns;
    timeprecision 1ps;

    // Free-running clock
    initial begin
        reset = 1'b0;
        forever #(HALF_NS) reset = ~reset;
    end

    // Reset held over two rising edges, released on a falling edge
    initial begin
        clk = 1'b1;
        repeat (2) @(posedge reset);
        @(negedge reset);
        clk <= 1'b0;
    end

endmodule

// File: tests/trig_unit_checker.sv
/*
 Handshake assertions for the trig unit, bound into every trig_unit instance.
 Watches req, ack and result on the rising edge of the unit clock.
*/
module trig_unit_checker
    import taylor_pkg::*;
(
    input logic reset,
    input logic clk,
    input logic req,
    input logic ack,
    input fix_t result
);

    timeunit 1ns;
    timeprecision 1ps;

    // ----------------------------------------------------------------------
    // Four-phase req/ack rules
    // ----------------------------------------------------------------------

    // ack only answers a pending req
    ack_needs_req_a: assert property (
        @(posedge reset) disable iff (clk) $rose(ack) |-> $past(req)
    ) else $error("ack rose while req was low");

    // No early release of ack
    ack_held_a: assert property (
        @(posedge reset) disable iff (clk) (ack && req) |=> ack
    ) else $error("ack fell while req was still high");

    // Result frozen for the whole ack window
    result_stable_a: assert property (
        @(posedge reset) disable iff (clk) ack |=> $stable(result)
    ) else $error("result changed while ack was high");

endmodule

bind trig_unit trig_unit_checker trig_unit_checker_i (
    .reset (reset),
    .clk   (clk),
    .req   (req),
    .ack   (ack),
    .result(result)
);

// File: tests/trig_unit_tb.sv
/*
 Testbench for the trig unit. Sends fixed and random requests through the
 req/ack handshake and compares each result with a bit-exact Taylor model.
*/
module trig_unit_tb
    import taylor_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_TERMS  = 11;
    // Cycles allowed for any single wait
    localparam int TIMEOUT  = 100;
    // pi/2 in Q2.16 rounded down
    localparam int HALF_PI  = 102943;
    localparam int N_RANDOM = 200;
    localparam int MAX_HOLD = 20;

    logic        reset;
    logic        clk;
    logic        req;
    func_t       func;
    fix_t        angle;
    logic        ack;
    fix_t        result;

    // Galois LFSR state
    logic [31:0] lfsr_state;

    tb_clock clock_i (
        .reset(reset),
        .clk  (clk)
    );

    trig_unit #(
        .N_TERMS(N_TERMS)
    ) trig_unit_i (
        .reset (reset),
        .clk   (clk),
        .req   (req),
        .func  (func),
        .angle (angle),
        .ack   (ack),
        .result(result)
    );

    // ----------------------------------------------------------------------
    // Random bits from x^32 + x^22 + x^2 + x + 1
    // ----------------------------------------------------------------------
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v          = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    // ----------------------------------------------------------------------
    // Reference model of the truncated series
    // ----------------------------------------------------------------------
    function automatic fix_t ref_trig(input func_t f, input fix_t x);
        longint term;
        longint factor;
        longint recip;
        longint sum;
        int     phase;
        int     n;
        // t_0 is 1.0
        term = longint'(1) <<< FRAC_BITS;
        sum  = 0;
        for (n = 0; n < N_TERMS; n++) begin
            if (n > 0) begin
                // 1/n rounded to nearest
                recip  = ((longint'(1) <<< FRAC_BITS) + n / 2) / n;
                factor = longint'(fix_t'((longint'(x) * recip) >>> FRAC_BITS));
                term   = longint'(fix_t'((term * factor) >>> FRAC_BITS));
            end
            // Derivative at zero cycles 0, +1, 0, -1
            phase = (int'(f) + n) % 4;
            if (phase == 1) begin
                sum = sum + term;
            end else if (phase == 3) begin
                sum = sum - term;
            end
        end
        return fix_t'(sum);
    endfunction

    // ----------------------------------------------------------------------
    // Checks and failure exits
    // ----------------------------------------------------------------------
    task automatic check_equal(input string what, input logic signed [63:0] got,
                               input logic signed [63:0] expected);
        if (got !== expected) begin
            $display("MISMATCH at %0t ns: %s, got %0d, expected %0d",
                     $time, what, got, expected);
            $display("Done: errors found");
            $fatal(1, "Compare failed");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout at %0t ns while waiting for %s", $time, what);
        $display("Done: errors found");
        $fatal(1, "Wait timed out");
    endtask

    // ----------------------------------------------------------------------
    // One full handshake entered and left on a falling edge
    // ----------------------------------------------------------------------
    task automatic run_request(input func_t f, input fix_t x, input int hold);
        fix_t  expected;
        fix_t  captured;
        int    cycles;
        string tag;
        expected = ref_trig(f, x);
        tag      = $sformatf("func %0d angle %0d", f, x);
        func  = f;
        angle = x;
        req   = 1'b1;

        cycles = 0;
        while (ack !== 1'b1) begin
            @(negedge reset);
            cycles++;
            if (cycles > TIMEOUT) begin
                report_timeout("ack to rise");
            end
        end
        captured = result;
        check_equal({"result, ", tag}, 64'(captured), 64'(expected));

        // Slow release of req while ack and result hold
        for (int i = 0; i < hold; i++) begin
            @(negedge reset);
            check_equal({"ack held, ", tag}, 64'(ack), 64'(1'b1));
            check_equal({"result held, ", tag}, 64'(result), 64'(captured));
        end

        req    = 1'b0;
        cycles = 0;
        while (ack !== 1'b0) begin
            check_equal({"result until ack falls, ", tag}, 64'(result), 64'(captured));
            @(negedge reset);
            cycles++;
            if (cycles > TIMEOUT) begin
                report_timeout("ack to fall");
            end
        end
    endtask

    // ----------------------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------------------
    initial begin
        logic [31:0] bits;
        int          cycles;
        int          mag;
        int          hold;
        fix_t        x;
        func_t       f;
        lfsr_state = 32'hf2da_a201;
        req        = 1'b0;
        func       = FN_SIN;
        angle      = '0;

        // Wait out reset
        cycles = 0;
        while (clk !== 1'b0) begin
            @(negedge reset);
            cycles++;
            if (cycles > TIMEOUT) begin
                report_timeout("reset release");
            end
        end
        @(negedge reset);
        check_equal("ack after reset", 64'(ack), 64'(1'b0));

        // Edge angles for every function back to back
        for (int k = 0; k < 4; k++) begin
            run_request(func_t'(k[1:0]), fix_t'(0), 0);
            run_request(func_t'(k[1:0]), fix_t'(HALF_PI), 0);
            run_request(func_t'(k[1:0]), fix_t'(-HALF_PI), 1);
        end

        // Random angle, function and release delay
        for (int i = 0; i < N_RANDOM; i++) begin
            draw_bits(17, bits);
            mag = int'(bits % 32'(HALF_PI + 1));
            draw_bits(1, bits);
            x = bits[0] ? fix_t'(-mag) : fix_t'(mag);
            draw_bits(2, bits);
            f = func_t'(bits[1:0]);
            draw_bits(5, bits);
            hold = int'(bits % 32'(MAX_HOLD + 1));
            run_request(f, x, hold);
        end

        $display("Done: no errors");
        $finish;
    end

endmodule

// File: compile.f
logic/taylor_pkg.sv
logic/taylor_coef_rom.sv
logic/dsp_mac.sv
logic/taylor_calc.sv
logic/trig_unit.sv
tests/tb_clock.sv
tests/trig_unit_checker.sv
tests/trig_unit_tb.sv

// File: run.sh
#!/bin/sh
# Builds the trig unit testbench with Verilator, runs it and scans the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert --top-module trig_unit_tb \
    --Mdir obj_dir -f compile.f > build.log 2>&1 \
    || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/Vtrig_unit_tb > sim.log 2>&1 || echo "Simulator exited with an error status"

grep -q "Done: errors found" sim.log && { echo "FAIL, see sim.log"; exit 1; }
grep -q "Done: no errors" sim.log || { echo "FAIL, run ended without a result"; exit 1; }
echo "PASS"
